// File: rtl/fe_dual_macros.svh
/*
  widths and constants for the dual-issue fetch front end
  address, instruction and control-transfer opcode values
*/
`ifndef FE_DUAL_MACROS_SVH
`define FE_DUAL_MACROS_SVH

// sv39 virtual address
`define FE_VADDR_W 39
`define FE_INSTR_W 32
`define FE_INSTR_BYTES 4

// risc-v major opcodes that end a fetch group
`define FE_OPC_BRANCH 7'b1100011
`define FE_OPC_JAL 7'b1101111
`define FE_OPC_JALR 7'b1100111

`endif

// File: rtl/fe_dual_pkg.sv
/*
  shared types of the fetch front end
  command, queue message, cache answer and state encodings
*/
`include "fe_dual_macros.svh"

package fe_dual_pkg;

  typedef logic [`FE_VADDR_W-1:0] fe_vaddr_t;
  typedef logic [`FE_INSTR_W-1:0] fe_instr_t;

  // commands from the back end
  typedef enum logic [1:0] {
    e_op_pc_redirect,
    e_op_state_reset,
    e_op_wait
  } fe_cmd_op_e;

  typedef struct packed {
    fe_cmd_op_e opcode;
    fe_vaddr_t  vaddr;
  } fe_cmd_s;

  typedef enum logic [1:0] {e_wait, e_run, e_stall} fe_state_e;

  // lane faults, misaligned has highest priority
  typedef enum logic [1:0] {
    e_instr_misaligned,
    e_instr_access_fault,
    e_icache_miss
  } fe_exc_code_e;

  typedef enum logic {e_fe_fetch, e_fe_exception} fe_msg_type_e;

  typedef struct packed {
    fe_msg_type_e msg_type;
    fe_vaddr_t    pc;
    fe_instr_t    instr;
    fe_exc_code_e exc_code;
  } fe_queue_s;

  typedef struct packed {
    fe_instr_t instr;
    logic      data_v;
    logic      access_fault;
  } fe_icache_resp_s;

endpackage

// File: rtl/fe_fetch_ctrl.sv
/*
  fetch controller
  command decode, wait/run/stall fsm, resume pc register
*/
`timescale 1ns/100ps

module fe_fetch_ctrl (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  fe_dual_pkg::fe_cmd_s  fe_cmd_i,
  input  logic                  fe_cmd_v_i,
  input  logic                  icache_ready_i,
  input  logic                  queue_ready_i,
  input  logic                  fail_i,
  input  logic                  exception_sent_i,
  input  logic                  squash_i,
  input  fe_dual_pkg::fe_vaddr_t if2_pc1_i,
  output logic                  redirect_v_o,
  output fe_dual_pkg::fe_vaddr_t redirect_pc_o,
  output logic                  advance_o,
  output logic                  poison_o
);
  import fe_dual_pkg::*;

  fe_state_e state_r, state_n;
  fe_vaddr_t resume_r;
  logic      imm_pending_r;

  wire is_run   = (state_r == e_run);
  wire is_stall = (state_r == e_stall);

  wire cmd_immediate_v = fe_cmd_v_i & (fe_cmd_i.opcode == e_op_pc_redirect);
  wire cmd_stall_v     = fe_cmd_v_i & ((fe_cmd_i.opcode == e_op_state_reset)
                                     | (fe_cmd_i.opcode == e_op_wait));
  wire unstall         = icache_ready_i & queue_ready_i;

  always_comb
  begin
    case (state_r)
      e_wait:  state_n = cmd_immediate_v ? e_run : (cmd_stall_v ? e_stall : e_wait);
      // a stall-type command restarts the stall with a new resume pc
      e_stall: state_n = cmd_immediate_v ? e_run
                       : (cmd_stall_v ? e_stall : (unstall ? e_run : e_stall));
      e_run:   state_n = cmd_immediate_v ? e_run
                       : ((cmd_stall_v | fail_i) ? e_stall
                       : (exception_sent_i ? e_wait : e_run));
      default: state_n = e_wait;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r       <= e_wait;
      imm_pending_r <= 1'b0;
    end
    else
    begin
      state_r       <= state_n;
      imm_pending_r <= cmd_immediate_v;
    end
  end

  // command vaddr wins, otherwise track the stage-2 pc while running
  always_ff @(posedge clk_i)
  begin
    if (fe_cmd_v_i | is_run)
      resume_r <= fe_cmd_v_i ? fe_cmd_i.vaddr : if2_pc1_i;
  end

  assign advance_o     = (state_n == e_run);
  // the redirect pc is taken straight into the request
  assign redirect_v_o  = advance_o & (is_stall | imm_pending_r);
  assign redirect_pc_o = resume_r;
  assign poison_o      = fe_cmd_v_i | fail_i | exception_sent_i | squash_i;

endmodule

// File: rtl/fe_pc_gen.sv
/*
  fetch pc pair generation
  next pc register and stage-2 pc tracking
*/
`timescale 1ns/100ps
`include "fe_dual_macros.svh"

module fe_pc_gen (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   redirect_v_i,
  input  fe_dual_pkg::fe_vaddr_t redirect_pc_i,
  input  logic                   squash_i,
  input  logic                   advance_i,
  output fe_dual_pkg::fe_vaddr_t fetch_pc1_o,
  output fe_dual_pkg::fe_vaddr_t fetch_pc2_o,
  output fe_dual_pkg::fe_vaddr_t if2_pc1_o,
  output fe_dual_pkg::fe_vaddr_t if2_pc2_o
);
  import fe_dual_pkg::*;

  localparam fe_vaddr_t step_one = fe_vaddr_t'(`FE_INSTR_BYTES);
  localparam fe_vaddr_t step_two = fe_vaddr_t'(2 * `FE_INSTR_BYTES);

  fe_vaddr_t pc_r;
  fe_vaddr_t if2_pc1_r;
  fe_vaddr_t if2_pc2_r;

  // a redirect goes out in the same cycle
  assign fetch_pc1_o = redirect_v_i ? redirect_pc_i : pc_r;
  assign fetch_pc2_o = fetch_pc1_o + step_one;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      pc_r <= '0;
    // restart at the squashed slot, the stage-1 pair is dropped
    else if (squash_i)
      pc_r <= if2_pc2_r;
    else if (advance_i)
      pc_r <= fetch_pc1_o + step_two;
  end

  // pair in stage 2, lines up with the cache answer
  always_ff @(posedge clk_i)
  begin
    if2_pc1_r <= fetch_pc1_o;
    if2_pc2_r <= fetch_pc2_o;
  end

  assign if2_pc1_o = if2_pc1_r;
  assign if2_pc2_o = if2_pc2_r;

endmodule

// File: rtl/fe_fetch_lane.sv
/*
  one fetch lane
  stage-2 valid bit and fault encoding of the cache answer
*/
`timescale 1ns/100ps
`include "fe_dual_macros.svh"

module fe_fetch_lane (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        advance_i,
  input  logic                        poison_i,
  input  fe_dual_pkg::fe_vaddr_t      pc_i,
  input  fe_dual_pkg::fe_icache_resp_s resp_i,
  output logic                        instr_v_o,
  output logic                        exception_v_o,
  output fe_dual_pkg::fe_exc_code_e   exc_code_o
);
  import fe_dual_pkg::*;

  localparam int unsigned off_w = $clog2(`FE_INSTR_BYTES);

  logic v_if2_r;
  logic misaligned;
  logic fault;

  // request of this cycle reaches stage 2 unless poisoned
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      v_if2_r <= 1'b0;
    else
      v_if2_r <= advance_i & ~poison_i;
  end

  assign misaligned = (pc_i[off_w-1:0] != '0);
  assign fault      = misaligned | resp_i.access_fault | ~resp_i.data_v;

  always_comb
  begin
    if (misaligned)
      exc_code_o = e_instr_misaligned;
    else if (resp_i.access_fault)
      exc_code_o = e_instr_access_fault;
    else
      exc_code_o = e_icache_miss;
  end

  assign exception_v_o = v_if2_r & fault;
  assign instr_v_o     = v_if2_r & ~fault;

endmodule

// File: rtl/fe_queue_pack.sv
/*
  fetch queue message formation
  slot-1 control-transfer scan, slot-2 squash, fail detection
*/
`timescale 1ns/100ps
`include "fe_dual_macros.svh"

module fe_queue_pack (
  input  logic                         instr_v1_i,
  input  logic                         exception_v1_i,
  input  fe_dual_pkg::fe_exc_code_e    exc_code1_i,
  input  logic                         instr_v2_i,
  input  logic                         exception_v2_i,
  input  fe_dual_pkg::fe_exc_code_e    exc_code2_i,
  input  logic                         queue_ready_i,
  input  fe_dual_pkg::fe_vaddr_t       if2_pc1_i,
  input  fe_dual_pkg::fe_vaddr_t       if2_pc2_i,
  input  fe_dual_pkg::fe_icache_resp_s resp1_i,
  input  fe_dual_pkg::fe_icache_resp_s resp2_i,
  output fe_dual_pkg::fe_queue_s       queue1_o,
  output fe_dual_pkg::fe_queue_s       queue2_o,
  output logic                         queue_v1_o,
  output logic                         queue_v2_o,
  output logic                         fail_o,
  output logic                         exception_sent_o,
  output logic                         squash_o
);
  import fe_dual_pkg::*;

  function automatic fe_queue_s form_msg(input logic exc_v, input fe_exc_code_e code,
                                         input fe_vaddr_t pc, input fe_instr_t instr);
    fe_queue_s msg;
    msg     = '0;
    msg.pc  = pc;
    if (exc_v)
    begin
      msg.msg_type = e_fe_exception;
      msg.exc_code = code;
    end
    else
    begin
      msg.msg_type = e_fe_fetch;
      msg.instr    = instr;
    end
    return msg;
  endfunction

  logic [6:0] opc1;
  logic       cti1;
  logic       lane_v;

  assign opc1   = resp1_i.instr[6:0];
  assign cti1   = (opc1 == `FE_OPC_BRANCH) | (opc1 == `FE_OPC_JAL) | (opc1 == `FE_OPC_JALR);
  assign lane_v = instr_v1_i | exception_v1_i | instr_v2_i | exception_v2_i;

  assign queue1_o = form_msg(exception_v1_i, exc_code1_i, if2_pc1_i, resp1_i.instr);
  assign queue2_o = form_msg(exception_v2_i, exc_code2_i, if2_pc2_i, resp2_i.instr);

  // slot 2 only follows a plain fetch in slot 1
  assign queue_v1_o = queue_ready_i & (instr_v1_i | exception_v1_i);
  assign queue_v2_o = queue_ready_i & instr_v1_i & ~cti1 & (instr_v2_i | exception_v2_i);

  assign fail_o           = lane_v & ~queue_ready_i;
  assign squash_o         = queue_v1_o & instr_v1_i & cti1;
  assign exception_sent_o = (queue_v1_o & exception_v1_i) | (queue_v2_o & exception_v2_i);

endmodule

// File: rtl/fe_top.sv
/*
  dual-issue fetch front end top level
  controller, pc generator, two lanes and queue packer
*/
`timescale 1ns/100ps

module fe_top (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  fe_dual_pkg::fe_cmd_s         fe_cmd_i,
  input  logic                         fe_cmd_v_i,
  output fe_dual_pkg::fe_vaddr_t       fetch_pc1_o,
  output fe_dual_pkg::fe_vaddr_t       fetch_pc2_o,
  output logic                         fetch_v_o,
  input  fe_dual_pkg::fe_icache_resp_s resp1_i,
  input  fe_dual_pkg::fe_icache_resp_s resp2_i,
  input  logic                         icache_ready_i,
  output fe_dual_pkg::fe_queue_s       queue1_o,
  output fe_dual_pkg::fe_queue_s       queue2_o,
  output logic                         queue_v1_o,
  output logic                         queue_v2_o,
  input  logic                         queue_ready_i
);
  import fe_dual_pkg::*;

  logic         redirect_v;
  fe_vaddr_t    redirect_pc;
  logic         poison;
  fe_vaddr_t    if2_pc1;
  fe_vaddr_t    if2_pc2;
  logic         instr_v1;
  logic         instr_v2;
  logic         exception_v1;
  logic         exception_v2;
  fe_exc_code_e exc_code1;
  fe_exc_code_e exc_code2;
  logic         fail;
  logic         exception_sent;
  logic         squash;

  // advance is the request strobe to the icache
  fe_fetch_ctrl ctrl_i (
    .clk_i(clk_i), .reset_i(reset_i), .fe_cmd_i(fe_cmd_i), .fe_cmd_v_i(fe_cmd_v_i),
    .icache_ready_i(icache_ready_i), .queue_ready_i(queue_ready_i), .fail_i(fail),
    .exception_sent_i(exception_sent), .squash_i(squash), .if2_pc1_i(if2_pc1),
    .redirect_v_o(redirect_v), .redirect_pc_o(redirect_pc), .advance_o(fetch_v_o),
    .poison_o(poison)
  );

  fe_pc_gen pc_gen_i (
    .clk_i(clk_i), .reset_i(reset_i), .redirect_v_i(redirect_v),
    .redirect_pc_i(redirect_pc), .squash_i(squash), .advance_i(fetch_v_o),
    .fetch_pc1_o(fetch_pc1_o), .fetch_pc2_o(fetch_pc2_o),
    .if2_pc1_o(if2_pc1), .if2_pc2_o(if2_pc2)
  );

  fe_fetch_lane lane1_i (
    .clk_i(clk_i), .reset_i(reset_i), .advance_i(fetch_v_o), .poison_i(poison),
    .pc_i(if2_pc1), .resp_i(resp1_i), .instr_v_o(instr_v1),
    .exception_v_o(exception_v1), .exc_code_o(exc_code1)
  );

  fe_fetch_lane lane2_i (
    .clk_i(clk_i), .reset_i(reset_i), .advance_i(fetch_v_o), .poison_i(poison),
    .pc_i(if2_pc2), .resp_i(resp2_i), .instr_v_o(instr_v2),
    .exception_v_o(exception_v2), .exc_code_o(exc_code2)
  );

  fe_queue_pack pack_i (
    .instr_v1_i(instr_v1), .exception_v1_i(exception_v1), .exc_code1_i(exc_code1),
    .instr_v2_i(instr_v2), .exception_v2_i(exception_v2), .exc_code2_i(exc_code2),
    .queue_ready_i(queue_ready_i), .if2_pc1_i(if2_pc1), .if2_pc2_i(if2_pc2),
    .resp1_i(resp1_i), .resp2_i(resp2_i), .queue1_o(queue1_o), .queue2_o(queue2_o),
    .queue_v1_o(queue_v1_o), .queue_v2_o(queue_v2_o), .fail_o(fail),
    .exception_sent_o(exception_sent), .squash_o(squash)
  );

endmodule

// File: testbench/tb_clock.sv
/*
  free-running clock for the testbench
*/
`timescale 1ns/100ps

module tb_clock #(
  parameter int period_ns = 4
) (
  output logic clk_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

endmodule

// File: testbench/fe_top_tb.sv
/*
  testbench of the dual-issue fetch front end
  stimulus table, icache model, expected message stream and compare tasks
*/
`timescale 1ns/100ps
`include "fe_dual_macros.svh"

module fe_top_tb;
  import fe_dual_pkg::*;

  typedef struct packed {
    fe_cmd_op_e  op;
    fe_vaddr_t   vaddr;
    logic [15:0] ready_pat;
    logic [7:0]  n_msgs;
  } stim_row_s;

  localparam int        num_rows    = 8;
  localparam int        msg_timeout = 200;
  localparam int        idle_cycles = 10;
  localparam fe_vaddr_t step        = fe_vaddr_t'(`FE_INSTR_BYTES);
  localparam fe_vaddr_t fault_base  = 39'h1c0;
  localparam fe_vaddr_t miss_pc     = 39'h160;

  logic            clk;
  logic            reset;
  fe_cmd_s         fe_cmd;
  logic            fe_cmd_v;
  fe_vaddr_t       fetch_pc1;
  fe_vaddr_t       fetch_pc2;
  logic            fetch_v;
  fe_icache_resp_s resp1;
  fe_icache_resp_s resp2;
  logic            icache_ready;
  fe_queue_s       queue1;
  fe_queue_s       queue2;
  logic            queue_v1;
  logic            queue_v2;
  logic            queue_ready;

  fe_instr_t imem [64];
  logic      is_cti [64];
  stim_row_s rows [num_rows];

  // model and checker state
  fe_vaddr_t   req_pc1, req_pc2;
  fe_vaddr_t   exp_pc, cmd_vaddr;
  logic        cmd_seen, stream_done, first_fetch_due, redirect_due;
  logic [15:0] cur_pat;
  int          got, row_cyc, icache_hold, cti_slot1_seen;

  tb_clock #(.period_ns(4)) clk_gen (.clk_o(clk));

  fe_top dut_i (
    .clk_i(clk), .reset_i(reset), .fe_cmd_i(fe_cmd), .fe_cmd_v_i(fe_cmd_v),
    .fetch_pc1_o(fetch_pc1), .fetch_pc2_o(fetch_pc2), .fetch_v_o(fetch_v),
    .resp1_i(resp1), .resp2_i(resp2), .icache_ready_i(icache_ready),
    .queue1_o(queue1), .queue2_o(queue2), .queue_v1_o(queue_v1), .queue_v2_o(queue_v2),
    .queue_ready_i(queue_ready)
  );

  task automatic stop_with_failure();
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic value_error(input string text);
    $display("Error at %0t ns: %s", $time, text);
    stop_with_failure();
  endtask

  task automatic run_failure(input string text);
    $display("%s", text);
    stop_with_failure();
  endtask

  task automatic compare_pc(input fe_vaddr_t actual, input fe_vaddr_t expected,
                            input string what);
    if (actual !== expected)
      value_error($sformatf("%s is 0x%0h, expected 0x%0h", what, actual, expected));
  endtask

  task automatic compare_msg(input fe_queue_s actual, input fe_queue_s expected);
    if (actual.msg_type !== expected.msg_type)
      value_error($sformatf("message at pc 0x%0h has type %s, expected %s", actual.pc,
                            actual.msg_type.name(), expected.msg_type.name()));
    compare_pc(actual.pc, expected.pc, "message pc");
    if (expected.msg_type == e_fe_fetch)
    begin
      if (actual.instr !== expected.instr)
        value_error($sformatf("instr at pc 0x%0h is 0x%0h, expected 0x%0h", actual.pc,
                              actual.instr, expected.instr));
    end
    else if (actual.exc_code !== expected.exc_code)
      value_error($sformatf("exception code at pc 0x%0h is %s, expected %s", actual.pc,
                            actual.exc_code.name(), expected.exc_code.name()));
  endtask

  task automatic plant_cti(input int idx, input logic [6:0] opc);
    imem[idx]   = {imem[idx][31:7], opc};
    is_cti[idx] = 1'b1;
  endtask

  // addi words whose fields depend on the whole index plus a few control transfers
  task automatic fill_imem();
    for (int i = 0; i < 64; i++)
    begin
      imem[i]   = {12'(3 * i + 1), 5'(i + 1), 3'b000, 5'(i), 7'b0010011};
      is_cti[i] = 1'b0;
    end
    plant_cti(4, `FE_OPC_JAL);
    plant_cti(9, `FE_OPC_BRANCH);
    plant_cti(11, `FE_OPC_BRANCH);
    plant_cti(13, `FE_OPC_JALR);
  endtask

  // opcode, vaddr, queue-ready pattern (bit per cycle of the row), messages
  task automatic load_rows();
    rows[0] = '{e_op_pc_redirect, 39'h100, 16'hffff, 8'd25};
    rows[1] = '{e_op_pc_redirect, 39'h108, 16'hb3d9, 8'd10};
    rows[2] = '{e_op_wait,        39'h114, 16'hffff, 8'd6};
    rows[3] = '{e_op_pc_redirect, 39'h102, 16'hffff, 8'd1};
    rows[4] = '{e_op_pc_redirect, 39'h1b8, 16'hfffb, 8'd3};
    rows[5] = '{e_op_pc_redirect, 39'h1bc, 16'hffff, 8'd2};
    rows[6] = '{e_op_state_reset, 39'h120, 16'h7bde, 8'd8};
    rows[7] = '{e_op_pc_redirect, 39'h134, 16'hefff, 8'd4};
  endtask

  function automatic fe_icache_resp_s icache_answer(input fe_vaddr_t pc);
    fe_icache_resp_s r;
    r.instr        = imem[pc[7:2]];
    r.data_v       = (pc != miss_pc);
    r.access_fault = (pc >= fault_base);
    return r;
  endfunction

  // misaligned first, then access fault, then missing data
  function automatic fe_queue_s expected_msg(input fe_vaddr_t pc);
    fe_queue_s m;
    m          = '0;
    m.pc       = pc;
    m.msg_type = e_fe_exception;
    if (pc[1:0] != 2'b00)
      m.exc_code = e_instr_misaligned;
    else if (pc >= fault_base)
      m.exc_code = e_instr_access_fault;
    else if (pc == miss_pc)
      m.exc_code = e_icache_miss;
    else
    begin
      m.msg_type = e_fe_fetch;
      m.instr    = imem[pc[7:2]];
    end
    return m;
  endfunction

  // the stream is sequential since a squash only refetches the slot-2 pc
  task automatic check_msg(input fe_queue_s msg);
    fe_queue_s expected;
    if (stream_done)
      value_error($sformatf("message at pc 0x%0h after an exception", msg.pc));
    expected = expected_msg(exp_pc);
    compare_msg(msg, expected);
    if (expected.msg_type == e_fe_exception)
      stream_done = 1'b1;
    exp_pc = exp_pc + step;
    got++;
  endtask

  task automatic observe(input logic cmd_cycle);
    fe_queue_s exp1;
    logic      slot1_cti;
    if (!queue_ready && (queue_v1 || queue_v2))
      value_error("queue valid while queue_ready is low");
    if (queue_v2 && !queue_v1)
      value_error("slot 2 valid without slot 1");
    if (!cmd_seen && (queue_v1 || (fetch_v && !cmd_cycle)))
      value_error("fetch or queue activity before the first command");
    if (!cmd_cycle)
    begin
      if (redirect_due && !fetch_v)
        value_error("no fetch request in the cycle after a redirect");
      if (first_fetch_due && !icache_ready && fetch_v)
        value_error("fetch request while stalled on the icache");
      if (first_fetch_due && fetch_v)
      begin
        compare_pc(fetch_pc1, cmd_vaddr, "first fetch pc1");
        compare_pc(fetch_pc2, cmd_vaddr + step, "first fetch pc2");
        first_fetch_due = 1'b0;
      end
      if (stream_done && fetch_v)
        value_error("fetch request after an exception");
      redirect_due = 1'b0;
    end
    if (queue_v1)
    begin
      exp1      = expected_msg(exp_pc);
      slot1_cti = (exp1.msg_type == e_fe_fetch) && is_cti[exp_pc[7:2]];
      check_msg(queue1);
      if (slot1_cti)
      begin
        cti_slot1_seen++;
        if (queue_v2)
          value_error("slot 2 sent after a control transfer in slot 1");
      end
    end
    if (queue_v2)
      check_msg(queue2);
  endtask

  task automatic start_stream(input fe_cmd_s cmd);
    exp_pc          = cmd.vaddr;
    cmd_vaddr       = cmd.vaddr;
    got             = 0;
    stream_done     = 1'b0;
    cmd_seen        = 1'b1;
    first_fetch_due = 1'b1;
    redirect_due    = (cmd.opcode == e_op_pc_redirect);
    icache_hold     = redirect_due ? 0 : 6;
  endtask

  // drive on the falling edge and sample a quarter period before the rising edge
  task automatic run_cycle(input logic cmd_v, input fe_cmd_s cmd);
    @(negedge clk);
    fe_cmd_v     = cmd_v;
    fe_cmd       = cmd;
    queue_ready  = cur_pat[row_cyc[3:0]];
    icache_ready = (icache_hold == 0);
    resp1        = icache_answer(req_pc1);
    resp2        = icache_answer(req_pc2);
    #1;
    observe(cmd_v);
    req_pc1 = fetch_pc1;
    req_pc2 = fetch_pc2;
    if (cmd_v)
      start_stream(cmd);
    else if (icache_hold > 0)
      icache_hold--;
    row_cyc++;
  endtask

  task automatic wait_messages(input int n);
    int cycles;
    cycles = 0;
    while (got < n && cycles < msg_timeout)
    begin
      run_cycle(1'b0, '0);
      cycles++;
    end
    if (got < n)
      run_failure($sformatf("timeout after %0d cycles waiting for %0d messages, %0d received",
                            cycles, n, got));
    if (stream_done && got != n)
      value_error($sformatf("stream ended after %0d messages, expected %0d", got, n));
  endtask

  initial
  begin
    reset        = 1'b1;
    fe_cmd       = '0;
    fe_cmd_v     = 1'b0;
    resp1        = '0;
    resp2        = '0;
    icache_ready = 1'b0;
    queue_ready  = 1'b0;
    req_pc1      = '0;
    req_pc2      = '0;
    exp_pc       = '0;
    cmd_vaddr    = '0;
    cmd_seen     = 1'b0;
    stream_done  = 1'b0;
    first_fetch_due = 1'b0;
    redirect_due = 1'b0;
    cur_pat      = 16'hffff;
    got          = 0;
    row_cyc      = 0;
    icache_hold  = 0;
    cti_slot1_seen = 0;
    fill_imem();
    load_rows();

    repeat (16) @(negedge clk);
    reset = 1'b0;

    // quiet front end until the first command
    for (int i = 0; i < 8; i++)
      run_cycle(1'b0, '0);

    for (int r = 0; r < num_rows; r++)
    begin
      cur_pat = rows[r].ready_pat;
      row_cyc = 0;
      run_cycle(1'b1, '{rows[r].op, rows[r].vaddr});
      wait_messages(int'(rows[r].n_msgs));
      for (int k = 0; k < idle_cycles; k++)
        run_cycle(1'b0, '0);
    end

    if (cti_slot1_seen == 0)
      run_failure("no control transfer reached slot 1, the squash path was not exercised");
    else
    begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

// File: files.f
+incdir+rtl
rtl/fe_dual_pkg.sv
rtl/fe_fetch_ctrl.sv
rtl/fe_pc_gen.sv
rtl/fe_fetch_lane.sv
rtl/fe_queue_pack.sv
rtl/fe_top.sv
testbench/tb_clock.sv
testbench/fe_top_tb.sv

// File: Makefile
# Verilator build and run of the fetch front end testbench
# pass or fail is the exit status of the simulation binary

VERILATOR  ?= verilator
TOP        ?= fe_top_tb
RTL_TOP    ?= fe_top
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
